/* sim.f */
hdl/gb_service_pkg.sv
hdl/svc_regs.sv
hdl/palette_loader.sv
hdl/cheat_loader.sv
hdl/ff_control.sv
hdl/backup_sync.sv
hdl/gb_cart_service.sv
tb/gb_cart_service_assertions.sv
tb/tb_gb_cart_service.sv

/* Bender.yml */
package:
  name: gb_cart_service

sources:
  - files:
      - hdl/gb_service_pkg.sv
      - hdl/svc_regs.sv
      - hdl/palette_loader.sv
      - hdl/cheat_loader.sv
      - hdl/ff_control.sv
      - hdl/backup_sync.sv
      - hdl/gb_cart_service.sv
  - target: simulation
    files:
      - tb/gb_cart_service_assertions.sv
      - tb/tb_gb_cart_service.sv

/* tb/tb_gb_cart_service.sv */
//////////////////////////////
// Directed tests for the cartridge service logic
// SD host model answers sector requests from a 4-sector image
// Save RAM reads return a fixed function of bk_addr
// Tap threshold is cut to 40 cycles to keep the run short
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_gb_cart_service
	import gb_service_pkg::*;
;

	// Two 4-sector transfers take about 2100 cycles, everything else a few hundred
	localparam int watchdog_cycles = 20000;

	logic                    clk_sys;
	logic                    reset;
	logic [axi_addr_w-1:0]   awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [axi_data_w-1:0]   wdata;
	logic [3:0]              wstrb;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [axi_addr_w-1:0]   araddr;
	logic                    arvalid;
	logic                    arready;
	logic [axi_data_w-1:0]   rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [ioctl_addr_w-1:0] ioctl_addr;
	logic [ioctl_data_w-1:0] ioctl_dout;
	logic [7:0]              filetype;
	logic                    osd_status;
	logic [23:0]             pal1;
	logic [23:0]             pal2;
	logic [23:0]             pal3;
	logic [23:0]             pal4;
	logic [cheat_code_w-1:0] cheat_code;
	logic                    cheat_valid;
	logic                    ff_button;
	logic [15:0]             audio_in_l;
	logic [15:0]             audio_in_r;
	logic                    fast_forward;
	logic [15:0]             audio_l;
	logic [15:0]             audio_r;
	logic                    img_mounted;
	logic                    img_readonly;
	logic [63:0]             img_size;
	logic                    sd_ack;
	logic [7:0]              sd_buff_addr;
	logic [ioctl_data_w-1:0] sd_buff_dout;
	logic                    sd_buff_wr;
	logic [sd_lba_w-1:0]     sd_lba;
	logic                    sd_rd;
	logic                    sd_wr;
	logic [ioctl_data_w-1:0] sd_buff_din;
	logic                    cram_wr;
	logic [ioctl_data_w-1:0] bk_q;
	logic [31:0]             rtc_timestamp;
	logic [47:0]             rtc_savedtime;
	logic [15:0]             bk_addr;
	logic                    bk_wr;
	logic                    bk_rtc_wr;
	logic [ioctl_data_w-1:0] bk_data;

	integer          seed;
	int              errors;
	int              checks;
	int              ram_writes;
	int              rtc_writes;
	int              cheat_pulses;
	logic [15:0]     sd_image [0:1023];
	logic [31:0]     lba_log [$];
	logic [1:0]      req_log [$];

	gb_cart_service #(
		.ff_tap_cycles(40)
	) dut (.*);

	always #5 clk_sys = ~clk_sys;

	// Cartridge RAM contents, a function of the full address
	assign bk_q = bk_addr ^ 16'hc3a5;

	//////////////////////////////
	// Helpers
	//////////////////////////////
	task automatic check(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do @(negedge clk_sys); while (!awready);
		check("wready", wready, 1'b1);
		tick();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		do @(negedge clk_sys); while (!bvalid);
		check("bresp", bresp, 2'b00);
		// Master takes the response one cycle late
		tick();
		bready = 1'b1;
		tick();
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		araddr  = addr;
		arvalid = 1'b1;
		do @(negedge clk_sys); while (!arready);
		tick();
		arvalid = 1'b0;
		rready  = 1'b1;
		do @(negedge clk_sys); while (!rvalid);
		data = rdata;
		check("rresp", rresp, 2'b00);
		tick();
		rready = 1'b0;
	endtask

	task automatic send_word(input logic [7:0] ft, input logic [24:0] addr,
		input logic [15:0] data);
		filetype   = ft;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		tick();
		ioctl_wr = 1'b0;
		tick();
	endtask

	task automatic press_button(input int hold);
		ff_button = 1'b1;
		repeat (hold) tick();
		ff_button = 1'b0;
	endtask

	task automatic compare_palette(input logic [127:0] model);
		check("pal1", pal1, model[127:104]);
		check("pal2", pal2, model[103:80]);
		check("pal3", pal3, model[79:56]);
		check("pal4", pal4, model[55:32]);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic check_register_map();
		logic [31:0] val;
		logic [31:0] rd;
		axi_read(reg_status, rd);
		check("status after reset", rd, 32'd0);
		axi_read(4'hc, rd);
		check("unmapped 0xc", rd, 32'd0);
		val = $random(seed);
		axi_write(reg_ctrl, val);
		axi_read(reg_ctrl, rd);
		check("ctrl", rd, {28'd0, val[3:2], 2'b00});
		val = $random(seed);
		axi_write(reg_cart, val);
		axi_read(reg_cart, rd);
		check("cart", rd, {22'd0, val[9:0]});
		axi_write(4'hc, 32'hffff_ffff);
		axi_read(4'hc, rd);
		check("unmapped 0xc after write", rd, 32'd0);
		axi_write(reg_ctrl, 32'd0);
		axi_write(reg_cart, 32'd0);
	endtask

	task automatic load_palette_words();
		logic [127:0] model;
		logic [15:0]  w;
		int           i;
		model = palette_reset;
		compare_palette(model);
		ioctl_download = 1'b1;
		for (i = 0; i < 8; i++) begin
			w = $random(seed);
			send_word(ft_palette, 25'(2 * i), w);
			model = {model[111:0], w[7:0], w[15:8]};
		end
		// Other file types leave the palette alone
		send_word(8'h05, 25'd0, 16'hbeef);
		send_word(8'h05, 25'd2, 16'h1234);
		ioctl_download = 1'b0;
		tick();
		compare_palette(model);
	endtask

	task automatic assemble_cheat_code();
		logic [15:0]  w [8];
		logic [127:0] exp;
		int           i;
		cheat_pulses   = 0;
		ioctl_download = 1'b1;
		for (i = 0; i < 8; i++) begin
			w[i] = $random(seed);
			send_word(ft_cheat, 25'(2 * i), w[i]);
		end
		ioctl_download = 1'b0;
		repeat (2) tick();
		exp = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		check("cheat_valid pulses", cheat_pulses, 1);
		check("cheat_code", cheat_code, exp);
	endtask

	task automatic exercise_fast_forward();
		audio_in_l = $random(seed);
		audio_in_r = $random(seed);
		press_button(10);
		repeat (3) tick();
		check("fast_forward after tap", fast_forward, 1'b1);
		axi_write(reg_ctrl, 32'h8);
		check("audio_l muted", audio_l, 16'd0);
		check("audio_r muted", audio_r, 16'd0);
		axi_write(reg_ctrl, 32'h0);
		check("audio_l passed", audio_l, audio_in_l);
		check("audio_r passed", audio_r, audio_in_r);
		press_button(100);
		repeat (3) tick();
		check("fast_forward after hold", fast_forward, 1'b0);
		// Menu open, button has no effect
		osd_status = 1'b1;
		press_button(10);
		repeat (3) tick();
		check("fast_forward with menu open", fast_forward, 1'b0);
		osd_status = 1'b0;
		tick();
	endtask

	task automatic restore_from_sd();
		logic [31:0] st;
		int          i;
		axi_write(reg_cart, 32'h0000_0302);
		lba_log.delete();
		req_log.delete();
		ram_writes     = 0;
		rtc_writes     = 0;
		img_mounted    = 1'b1;
		img_size       = 64'h8000;
		ioctl_download = 1'b1;
		for (i = 0; i < 4; i++)
			send_word(ft_cart_gb, 25'(2 * i), 16'(i));
		ioctl_download = 1'b0;
		img_mounted    = 1'b0;
		do axi_read(reg_status, st); while (!st[0]);
		check("status during load", st, 32'hb);
		do axi_read(reg_status, st); while (st[0]);
		check("status after load", st, 32'h8);
		check("sectors read", lba_log.size(), 4);
		for (i = 0; i < lba_log.size(); i++) begin
			check("sd_lba on load", lba_log[i], i);
			check("sd_rd and sd_wr on load", req_log[i], 2'b10);
		end
		check("bk_wr count", ram_writes, 768);
		check("bk_rtc_wr count", rtc_writes, 256);
	endtask

	task automatic autosave_to_sd();
		logic [31:0] st;
		logic [31:0] ts;
		logic [47:0] sv;
		int          i;
		axi_write(reg_ctrl, 32'h4);
		cram_wr = 1'b1;
		tick();
		cram_wr = 1'b0;
		axi_read(reg_status, st);
		check("status with save pending", st, 32'hc);
		ts            = $random(seed);
		sv[31:0]      = $random(seed);
		sv[47:32]     = 16'($random(seed));
		rtc_timestamp = ts;
		rtc_savedtime = sv;
		lba_log.delete();
		req_log.delete();
		// Opening the menu triggers the autosave
		osd_status = 1'b1;
		do axi_read(reg_status, st); while (!st[0]);
		do axi_read(reg_status, st); while (st[0]);
		osd_status = 1'b0;
		check("status after save", st, 32'h8);
		check("sectors written", lba_log.size(), 4);
		for (i = 0; i < lba_log.size(); i++) begin
			check("sd_lba on save", lba_log[i], i);
			check("sd_rd and sd_wr on save", req_log[i], 2'b01);
		end
		check("rtc word 0", sd_image[768], ts[15:0]);
		check("rtc word 1", sd_image[769], ts[31:16]);
		check("rtc word 2", sd_image[770], sv[15:0]);
		check("rtc word 3", sd_image[771], sv[31:16]);
		check("rtc word 4", sd_image[772], sv[47:32]);
		check("rtc word 5", sd_image[773], 16'hffff);
		check("save word 1:16", sd_image[272], 16'h0110 ^ 16'hc3a5);
	endtask

	//////////////////////////////
	// SD host model and monitors
	//////////////////////////////
	initial begin : sd_host
		logic [1:0] sector;
		logic       reading;
		int         i;
		sd_ack       = 1'b0;
		sd_buff_addr = 8'd0;
		sd_buff_dout = 16'd0;
		sd_buff_wr   = 1'b0;
		for (i = 0; i < 1024; i++)
			sd_image[i] = 16'(i) ^ 16'h5a3c;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				sector  = sd_lba[1:0];
				reading = sd_rd;
				lba_log.push_back(sd_lba);
				req_log.push_back({sd_rd, sd_wr});
				tick();
				sd_ack = 1'b1;
				for (i = 0; i < 256; i++) begin
					sd_buff_addr = i[7:0];
					sd_buff_wr   = reading;
					sd_buff_dout = sd_image[{sector, i[7:0]}];
					@(negedge clk_sys);
					check("bk_addr", bk_addr, {6'd0, sector, i[7:0]});
					if (reading)
						check("bk_data", bk_data, sd_image[{sector, i[7:0]}]);
					else
						sd_image[{sector, i[7:0]}] = sd_buff_din;
					tick();
				end
				sd_ack     = 1'b0;
				sd_buff_wr = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (bk_wr)
			ram_writes++;
		if (bk_rtc_wr)
			rtc_writes++;
		if (cheat_valid)
			cheat_pulses++;
	end

	initial begin : watchdog
		#(watchdog_cycles * 10);
		$display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

	initial begin : main
		int assert_fails;
		seed           = 32'hb210_49dd;
		clk_sys        = 1'b0;
		reset          = 1'b1;
		awaddr         = '0;
		awvalid        = 1'b0;
		wdata          = '0;
		wstrb          = 4'h0;
		wvalid         = 1'b0;
		bready         = 1'b0;
		araddr         = '0;
		arvalid        = 1'b0;
		rready         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		filetype       = 8'd0;
		osd_status     = 1'b0;
		ff_button      = 1'b0;
		audio_in_l     = 16'd0;
		audio_in_r     = 16'd0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = 64'd0;
		cram_wr        = 1'b0;
		rtc_timestamp  = 32'd0;
		rtc_savedtime  = 48'd0;
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		check_register_map();
		load_palette_words();
		assemble_cheat_code();
		exercise_fast_forward();
		restore_from_sd();
		autosave_to_sd();
		assert_fails = dut.u_assertions.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/gb_cart_service_assertions.sv */
//////////////////////////////
// Protocol rules for the cartridge service top level
// Bound into gb_cart_service, checked only outside reset
// fail_count is read back by the testbench at the end of the run
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gb_cart_service_assertions (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic bvalid,
	input logic bready,
	input logic cheat_valid
);

	int fail_count;

	// One SD request direction at a time
	sd_req_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else begin
			fail_count++;
			$error("sd_rd and sd_wr are high together");
		end

	// Write response waits for the master
	bvalid_hold: assert property (@(posedge clk_sys) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else begin
			fail_count++;
			$error("bvalid dropped before bready");
		end

	cheat_single_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid)
		else begin
			fail_count++;
			$error("cheat_valid stayed high for two cycles");
		end

endmodule

bind gb_cart_service gb_cart_service_assertions u_assertions (.*);

`default_nettype wire

/* hdl/gb_cart_service.sv */
//////////////////////////////
// Cartridge service top level, single clk_sys domain
// Registers steer backup RAM and fast-forward, status reads back over AXI
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gb_cart_service
	import gb_service_pkg::*;
#(
	parameter int ff_tap_cycles = 3200000
) (
	input  logic                    clk_sys,
	input  logic                    reset,

	// AXI4-Lite register port
	input  logic [axi_addr_w-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [axi_data_w-1:0]   wdata,
	input  logic [3:0]              wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [axi_addr_w-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [axi_data_w-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,

	// Host download stream
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [ioctl_addr_w-1:0] ioctl_addr,
	input  logic [ioctl_data_w-1:0] ioctl_dout,
	input  logic [7:0]              filetype,
	input  logic                    osd_status,

	output logic [23:0]             pal1,
	output logic [23:0]             pal2,
	output logic [23:0]             pal3,
	output logic [23:0]             pal4,
	output logic [cheat_code_w-1:0] cheat_code,
	output logic                    cheat_valid,

	// Fast-forward and audio
	input  logic                    ff_button,
	input  logic [15:0]             audio_in_l,
	input  logic [15:0]             audio_in_r,
	output logic                    fast_forward,
	output logic [15:0]             audio_l,
	output logic [15:0]             audio_r,

	// Image and SD sector port
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [63:0]             img_size,
	input  logic                    sd_ack,
	input  logic [7:0]              sd_buff_addr,
	input  logic [ioctl_data_w-1:0] sd_buff_dout,
	input  logic                    sd_buff_wr,
	output logic [sd_lba_w-1:0]     sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output logic [ioctl_data_w-1:0] sd_buff_din,

	// Save RAM and clock
	input  logic                    cram_wr,
	input  logic [ioctl_data_w-1:0] bk_q,
	input  logic [31:0]             rtc_timestamp,
	input  logic [47:0]             rtc_savedtime,
	output logic [15:0]             bk_addr,
	output logic                    bk_wr,
	output logic                    bk_rtc_wr,
	output logic [ioctl_data_w-1:0] bk_data
);

	logic       load_req;
	logic       save_req;
	logic       autosave_en;
	logic       ff_mute_en;
	logic [7:0] ram_mask;
	logic       rtc_inuse;
	logic       has_save;
	logic       bk_busy;
	logic       bk_loading;
	logic       sav_pending;
	logic       sav_supported;

	svc_regs u_regs (
		.clk_sys, .reset,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.load_req, .save_req, .autosave_en, .ff_mute_en,
		.ram_mask, .rtc_inuse, .has_save,
		.bk_busy, .bk_loading, .sav_pending, .sav_supported, .fast_forward
	);

	palette_loader u_palette (
		.clk_sys, .reset, .ioctl_download, .ioctl_wr, .filetype, .ioctl_dout,
		.pal1, .pal2, .pal3, .pal4
	);

	cheat_loader u_cheat (
		.clk_sys, .reset, .ioctl_download, .ioctl_wr, .filetype,
		.ioctl_addr, .ioctl_dout, .cheat_code, .cheat_valid
	);

	ff_control #(
		.ff_tap_cycles(ff_tap_cycles)
	) u_ff (
		.clk_sys, .reset, .ff_button, .osd_status, .ioctl_download, .ff_mute_en,
		.audio_in_l, .audio_in_r, .fast_forward, .audio_l, .audio_r
	);

	backup_sync u_backup (
		.clk_sys, .reset, .ioctl_download, .filetype,
		.img_mounted, .img_readonly, .img_size, .osd_status, .cram_wr,
		.load_req, .save_req, .autosave_en, .ram_mask, .rtc_inuse, .has_save,
		.sd_ack, .sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .bk_q,
		.rtc_timestamp, .rtc_savedtime,
		.sd_lba, .sd_rd, .sd_wr, .sd_buff_din,
		.bk_addr, .bk_wr, .bk_rtc_wr, .bk_data,
		.bk_busy, .bk_loading, .sav_pending, .sav_supported
	);

endmodule

`default_nettype wire

/* hdl/backup_sync.sv */
//////////////////////////////
// Save RAM transfer to and from the SD sector interface
// Sectors 0 to ram_mask hold save RAM, one more carries clock data
// Host must hold sd_ack for the whole 256-word sector
// Save data on sd_buff_din comes straight from bk_q
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module backup_sync
	import gb_service_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic [7:0]              filetype,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [63:0]             img_size,
	input  logic                    osd_status,
	input  logic                    cram_wr,
	input  logic                    load_req,
	input  logic                    save_req,
	input  logic                    autosave_en,
	input  logic [7:0]              ram_mask,
	input  logic                    rtc_inuse,
	input  logic                    has_save,
	input  logic                    sd_ack,
	input  logic [7:0]              sd_buff_addr,
	input  logic [ioctl_data_w-1:0] sd_buff_dout,
	input  logic                    sd_buff_wr,
	input  logic [ioctl_data_w-1:0] bk_q,
	input  logic [31:0]             rtc_timestamp,
	input  logic [47:0]             rtc_savedtime,
	output logic [sd_lba_w-1:0]     sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output logic [ioctl_data_w-1:0] sd_buff_din,
	output logic [15:0]             bk_addr,
	output logic                    bk_wr,
	output logic                    bk_rtc_wr,
	output logic [ioctl_data_w-1:0] bk_data,
	output logic                    bk_busy,
	output logic                    bk_loading,
	output logic                    sav_pending,
	output logic                    sav_supported
);

	logic cart_dl;
	logic old_dl;
	logic dl_end;
	logic bk_ena;
	logic bk_save;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic rtc_sector;
	logic last_sector;

	assign cart_dl = ioctl_download &
		(filetype == ft_cart_gb || filetype == ft_cart_gbc || filetype == ft_cart_alt);
	assign dl_end        = old_dl & ~cart_dl;
	assign sav_supported = has_save & bk_ena;
	assign bk_save       = save_req | (sav_pending & osd_status & autosave_en);

	//////////////////////////////
	// Save RAM and clock data path
	//////////////////////////////
	assign rtc_sector = sd_lba[7:0] > ram_mask;
	assign bk_addr    = {sd_lba[7:0], sd_buff_addr};
	assign bk_data    = sd_buff_dout;
	assign bk_wr      = ~rtc_sector & sd_buff_wr & sd_ack;
	assign bk_rtc_wr  = rtc_sector & sd_buff_wr & sd_ack;

	always_comb begin
		if (!rtc_sector)
			sd_buff_din = bk_q;
		else begin
			case (sd_buff_addr)
				8'd0:    sd_buff_din = rtc_timestamp[15:0];
				8'd1:    sd_buff_din = rtc_timestamp[31:16];
				8'd2:    sd_buff_din = rtc_savedtime[15:0];
				8'd3:    sd_buff_din = rtc_savedtime[31:16];
				8'd4:    sd_buff_din = rtc_savedtime[47:32];
				default: sd_buff_din = 16'hffff;
			endcase
		end
	end

	// Clock sector follows the last save RAM sector when a clock is in use
	assign last_sector = rtc_inuse ? rtc_sector : (sd_lba[7:0] >= ram_mask);

	//////////////////////////////
	// Enable and pending save
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_dl      <= 1'b0;
			bk_ena      <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			old_dl <= cart_dl;
			if (cart_dl && !old_dl)
				bk_ena <= 1'b0;
			// Save image is mounted before the download completes
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (bk_busy)
				sav_pending <= 1'b0;
		end
	end

	//////////////////////////////
	// Sector sequencer
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= bk_save;
			old_ack  <= sd_ack;
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!bk_busy) begin
				if (bk_ena && ((load_req && !old_load) || (bk_save && !old_save))) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_req;
					sd_lba     <= '0;
					sd_rd      <= load_req;
					sd_wr      <= ~load_req;
				end
				if (dl_end && |img_size && bk_ena) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				if (last_sector) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/ff_control.sv */
//////////////////////////////
// Fast-forward button, a short tap latches and a hold is momentary
// Button is ignored during downloads and while the menu is open
// Tap threshold is given in clk_sys cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ff_control #(
	parameter int ff_tap_cycles = 3200000
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ff_button,
	input  logic        osd_status,
	input  logic        ioctl_download,
	input  logic        ff_mute_en,
	input  logic [15:0] audio_in_l,
	input  logic [15:0] audio_in_r,
	output logic        fast_forward,
	output logic [15:0] audio_l,
	output logic [15:0] audio_r
);

	localparam int cnt_w = $clog2(ff_tap_cycles + 1);

	logic             ff_q;
	logic             ff_last;
	logic             ff_latch;
	logic             ff_was_held;
	logic [cnt_w-1:0] ff_count;

	assign ff_q = ff_button & ~ioctl_download & ~osd_status;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ff_last      <= 1'b0;
			ff_latch     <= 1'b0;
			ff_was_held  <= 1'b0;
			ff_count     <= '0;
			fast_forward <= 1'b0;
		end else begin
			ff_last <= ff_q;
			// Counter saturates at the threshold
			if (ff_q && ff_count != cnt_w'(ff_tap_cycles))
				ff_count <= ff_count + 1'b1;
			if (ff_q && !ff_last) begin
				ff_latch <= 1'b0;
				ff_count <= '0;
			end
			// A tap following a latching tap only releases the latch
			if (!ff_q && ff_last) begin
				ff_was_held <= 1'b0;
				if (ff_count < cnt_w'(ff_tap_cycles) && !ff_was_held) begin
					ff_was_held <= 1'b1;
					ff_latch    <= 1'b1;
				end
			end
			fast_forward <= ff_q | ff_latch;
		end
	end

	assign audio_l = (fast_forward && ff_mute_en) ? 16'd0 : audio_in_l;
	assign audio_r = (fast_forward && ff_mute_en) ? 16'd0 : audio_in_r;

endmodule

`default_nettype wire

/* hdl/cheat_loader.sv */
//////////////////////////////
// Cheat code assembly from 16-bit download words
// Fields are big endian as produced by the loader
// The word at offset 14 completes a code
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cheat_loader
	import gb_service_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [7:0]              filetype,
	input  logic [ioctl_addr_w-1:0] ioctl_addr,
	input  logic [ioctl_data_w-1:0] ioctl_dout,
	output logic [cheat_code_w-1:0] cheat_code,
	output logic                    cheat_valid
);

	logic code_wr;

	assign code_wr = ioctl_download & ioctl_wr & (filetype == ft_cheat);

	// Layout: flags 127:96, address 95:64, compare 63:32, replace 31:0
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= ioctl_dout;
				4'd2:  cheat_code[127:112] <= ioctl_dout;
				4'd4:  cheat_code[79:64]   <= ioctl_dout;
				4'd6:  cheat_code[95:80]   <= ioctl_dout;
				4'd8:  cheat_code[47:32]   <= ioctl_dout;
				4'd10: cheat_code[63:48]   <= ioctl_dout;
				4'd12: cheat_code[15:0]    <= ioctl_dout;
				4'd14: cheat_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Strobe lines up with the last field landing
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr && ioctl_addr[3:0] == 4'd14;
	end

endmodule

`default_nettype wire

/* hdl/palette_loader.sv */
//////////////////////////////
// Custom palette, four 24-bit colours in the top 96 bits
// Download words are byte swapped on the way in
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module palette_loader
	import gb_service_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [7:0]              filetype,
	input  logic [ioctl_data_w-1:0] ioctl_dout,
	output logic [23:0]             pal1,
	output logic [23:0]             pal2,
	output logic [23:0]             pal3,
	output logic [23:0]             pal4
);

	logic [palette_w-1:0] palette;

	always_ff @(posedge clk_sys) begin
		if (reset)
			palette <= palette_reset;
		else if (ioctl_download && ioctl_wr && filetype == ft_palette)
			palette <= {palette[palette_w-17:0], ioctl_dout[7:0], ioctl_dout[15:8]};
	end

	// Lowest 32 bits are unused padding
	assign pal1 = palette[127:104];
	assign pal2 = palette[103:80];
	assign pal3 = palette[79:56];
	assign pal4 = palette[55:32];

endmodule

`default_nettype wire

/* hdl/svc_regs.sv */
//////////////////////////////
// AXI4-Lite slave, one outstanding write and one outstanding read
// Write address and data must arrive together, responses are always OKAY
// Unmapped offsets read zero and ignore writes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module svc_regs
	import gb_service_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,

	input  logic [axi_addr_w-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [axi_data_w-1:0] wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [axi_addr_w-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [axi_data_w-1:0] rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,

	output logic                  load_req,
	output logic                  save_req,
	output logic                  autosave_en,
	output logic                  ff_mute_en,
	output logic [7:0]            ram_mask,
	output logic                  rtc_inuse,
	output logic                  has_save,

	input  logic                  bk_busy,
	input  logic                  bk_loading,
	input  logic                  sav_pending,
	input  logic                  sav_supported,
	input  logic                  fast_forward
);

	logic                  wr_take;
	logic                  rd_take;
	logic                  ctrl_b0;
	logic [axi_data_w-1:0] rd_word;

	// Write needs both channels and a free response slot
	assign wr_take = awvalid & wvalid & ~bvalid;
	assign rd_take = arvalid & ~rvalid;
	assign awready = wr_take;
	assign wready  = wr_take;
	assign arready = rd_take;
	assign bresp   = 2'b00;
	assign rresp   = 2'b00;
	assign ctrl_b0 = wr_take & (awaddr == reg_ctrl) & wstrb[0];

	//////////////////////////////
	// Write side
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bvalid      <= 1'b0;
			load_req    <= 1'b0;
			save_req    <= 1'b0;
			autosave_en <= 1'b0;
			ff_mute_en  <= 1'b0;
			ram_mask    <= 8'd0;
			rtc_inuse   <= 1'b0;
			has_save    <= 1'b0;
		end else begin
			// Request bits only ever last one cycle
			load_req <= ctrl_b0 & wdata[0];
			save_req <= ctrl_b0 & wdata[1];
			if (ctrl_b0) begin
				autosave_en <= wdata[2];
				ff_mute_en  <= wdata[3];
			end
			if (wr_take && awaddr == reg_cart) begin
				if (wstrb[0])
					ram_mask <= wdata[7:0];
				if (wstrb[1]) begin
					rtc_inuse <= wdata[8];
					has_save  <= wdata[9];
				end
			end
			if (wr_take)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	//////////////////////////////
	// Read side
	//////////////////////////////
	always_comb begin
		rd_word = '0;
		case (araddr)
			reg_ctrl:   rd_word[3:2] = {ff_mute_en, autosave_en};
			reg_cart:   rd_word[9:0] = {has_save, rtc_inuse, ram_mask};
			reg_status: rd_word[4:0] = {fast_forward, sav_supported, sav_pending,
				bk_loading, bk_busy};
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rvalid <= 1'b0;
			rdata  <= '0;
		end else if (rd_take) begin
			rvalid <= 1'b1;
			rdata  <= rd_word;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/gb_service_pkg.sv */
//////////////////////////////
// Shared constants for the cartridge service logic
// Download words are 16 bits wide, file types come from the host loader
// Register offsets are byte addresses on a 4-bit AXI4-Lite bus
//////////////////////////////
`default_nettype none

package gb_service_pkg;

	// Download stream
	localparam int ioctl_data_w = 16;
	localparam int ioctl_addr_w = 25;

	// File types as tagged by the host loader
	localparam logic [7:0] ft_cart_gb  = 8'h01;
	localparam logic [7:0] ft_cart_gbc = 8'h41;
	localparam logic [7:0] ft_cart_alt = 8'h80;
	localparam logic [7:0] ft_palette  = 8'd3;
	localparam logic [7:0] ft_cheat    = 8'hff;

	// Palette and cheat payloads
	localparam int palette_w    = 128;
	localparam int cheat_code_w = 128;
	localparam logic [palette_w-1:0] palette_reset = 128'h828214517356305A5F1A3B4900000000;

	// SD sector port
	localparam int sd_lba_w = 32;

	// Register block
	localparam int axi_addr_w = 4;
	localparam int axi_data_w = 32;
	localparam logic [axi_addr_w-1:0] reg_ctrl   = 4'h0;
	localparam logic [axi_addr_w-1:0] reg_cart   = 4'h4;
	localparam logic [axi_addr_w-1:0] reg_status = 4'h8;

endpackage

`default_nettype wire
